//--- tests/psgStimulus.txt
1  0 0100 04  0
1  5 0a30 06  5
1  7 fffe 03  7
2  1 0200 03  2 0300 03  2
2  6 1000 01  7 2000 01  7
8  0 0000 02  1 0010 02  2 0020 02  3 0030 02  4 0040 02  5 0050 02  6 0060 02  7 0070 02  7
2  4 0400 00  2 0500 03  2
3  3 0f00 05  6 0e00 02  0 0d00 01  6
2  1 4000 14  0 5000 05  1
1  3 abcd 07  3
1  0 0010 01  0
0

//--- tb.f
verilog/psgPkg.sv
verilog/psgCeGen.sv
verilog/psgBusArb.sv
verilog/psgFetchCtl.sv
verilog/psgWaveChannel.sv
verilog/psgWaveFetch.sv
tests/psgFetchChecker.sv
tests/tbPsgWaveFetch.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tbPsgWaveFetch
FILELIST  ?= tb.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILDDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- tests/tbPsgWaveFetch.sv
`timescale 1ns/1ps

module tbPsgWaveFetch;

	import psgPkg::*;

	localparam int MaxTests = 32;

	logic               clk;
	logic               rst;
	logic [NumChan-1:0] start;
	busAddrT            baseAddr [NumChan];
	wordCntT            length [NumChan];
	sampleT             sysData;
	logic               sysAck;
	logic               sysCyc;
	busAddrT            sysAdr;
	chanIdxT            grantChan;
	sampleT             chanSample [NumChan];
	logic [NumChan-1:0] chanActive;
	logic               testDone;
	int                 testNum;
	int                 expOwner;
	int                 failCount;

	// tests as read from the stimulus file
	logic [NumChan-1:0] stimStart [MaxTests];
	busAddrT            stimBase [MaxTests][NumChan];
	wordCntT            stimLen [MaxTests][NumChan];
	int                 stimOwner [MaxTests];
	int                 numTests = 0;
	int                 totalWords = 0;
	int                 cycles = 0;
	int                 cycleLimit = 0;
	logic [31:0]        rngState = 32'h01e78580;

	psgWaveFetch u_dut (.*);
	psgFetchChecker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// run limit comes from the total word count of the stimulus
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout after %0d clocks, the fetches never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// ======================================================================
	// bus memory, answers each read after 1 to 4 clocks
	// ======================================================================

	initial begin
		int lat;
		sysAck = 1'b0;
		sysData = '0;
		forever begin
			@(posedge clk);
			#1;
			if (sysCyc) begin
				rngState = xorshift(rngState);
				lat = int'(rngState[1:0]) + 1;
				repeat (lat - 1) begin
					@(posedge clk);
					#1;
				end
				sysData = sysAdr[11:0] ^ 12'h5a5;
				sysAck = 1'b1;
				@(posedge clk);
				#1;
				sysAck = 1'b0;
			end
		end
	end

	// line: start count, then channel, base and length per start, then the last owner
	task automatic readStimulus(output bit ok);
		int fd;
		int r;
		int n;
		int ch;
		int b;
		int l;
		ok = 1'b0;
		fd = $fopen("tests/psgStimulus.txt", "r");
		if (fd == 0)
			return;
		r = $fscanf(fd, "%d", n);
		while (r == 1 && n > 0 && numTests < MaxTests) begin
			stimStart[numTests] = '0;
			for (int i = 0; i < n; i++) begin
				r = $fscanf(fd, "%d %h %h", ch, b, l);
				stimStart[numTests][ch] = 1'b1;
				stimBase[numTests][ch] = busAddrT'(b);
				stimLen[numTests][ch] = wordCntT'(l);
				totalWords += l;
			end
			r = $fscanf(fd, "%d", stimOwner[numTests]);
			numTests++;
			r = $fscanf(fd, "%d", n);
		end
		// a zero count marks the end of the list
		ok = (r == 1 && n == 0);
		$fclose(fd);
	endtask

	task automatic signalTestEnd(input int num);
		testNum = num;
		testDone = 1'b1;
		@(posedge clk);
		#1;
		testDone = 1'b0;
	endtask

	task automatic runTest(input int t);
		for (int c = 0; c < NumChan; c++) begin
			baseAddr[c] = stimBase[t][c];
			length[c] = stimLen[t][c];
		end
		start = stimStart[t];
		expOwner = stimOwner[t];
		@(posedge clk);
		#1;
		start = '0;
		while (chanActive != '0) begin
			@(posedge clk);
			#1;
		end
		// stay idle over several ce pulses so the held owner shows
		repeat (4 * u_dut.CeDiv) @(posedge clk);
		#1;
		signalTestEnd(t + 1);
	endtask

	initial begin
		bit ok;
		rst = 1'b1;
		start = '0;
		testDone = 1'b0;
		testNum = 0;
		expOwner = 0;
		for (int c = 0; c < NumChan; c++) begin
			baseAddr[c] = '0;
			length[c] = '0;
		end
		readStimulus(ok);
		if (!ok) begin
			$display("stimulus file could not be read or has no end marker");
			$display("Test failed");
			$finish;
		end else begin
			cycleLimit = 64 * totalWords + 200;
			repeat (5) @(posedge clk);
			#1;
			rst = 1'b0;
			// idle time after reset is test 0
			repeat (3 * u_dut.CeDiv) @(posedge clk);
			#1;
			signalTestEnd(0);
			for (int t = 0; t < numTests; t++) begin
				runTest(t);
			end
			$display("%0d tests run, %0d passed, %0d failed", numTests + 1,
				numTests + 1 - failCount, failCount);
			if (failCount == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

//--- tests/psgFetchChecker.sv
`timescale 1ns/1ps

module psgFetchChecker (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [psgPkg::NumChan-1:0] start,
	input  psgPkg::busAddrT            baseAddr [psgPkg::NumChan],
	input  psgPkg::wordCntT            length [psgPkg::NumChan],
	input  logic                       sysCyc,
	input  psgPkg::busAddrT            sysAdr,
	input  logic                       sysAck,
	input  psgPkg::chanIdxT            grantChan,
	input  psgPkg::sampleT             chanSample [psgPkg::NumChan],
	input  logic [psgPkg::NumChan-1:0] chanActive,
	input  logic                       testDone,
	input  int                         testNum,
	input  int                         expOwner,
	output int                         failCount
);

	import psgPkg::*;

	int      remain [NumChan] = '{default: 0};
	busAddrT nextAddr [NumChan] = '{default: '0};
	sampleT  expSample [NumChan] = '{default: '0};
	int      errs = 0;
	int      fails = 0;
	int      owner = -1;
	int      lastOwner = 0;
	logic    cycPrev = 1'b0;
	logic    acked = 1'b1;
	logic    started = 1'b0;

	assign failCount = fails;

	task automatic flagError(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		errs++;
	endtask

	task automatic checkSample(input int c);
		if (chanSample[c] != expSample[c])
			flagError($sformatf("channel %0d sample %h, expected %h", c,
				chanSample[c], expSample[c]));
	endtask

	// lowest channel with words left or -1 when all are done
	function automatic int nextOwner();
		for (int c = 0; c < NumChan; c++) begin
			if (remain[c] > 0)
				return c;
		end
		return -1;
	endfunction

	// ======================================================================
	// bus order and sample prediction at the falling edge
	// ======================================================================

	always @(negedge clk) begin
		if (!rst) begin
			if (!started) begin
				if (sysCyc || grantChan != '0 || chanActive != '0)
					flagError("bus or channels left the reset state before any start");
				for (int c = 0; c < NumChan; c++) begin
					checkSample(c);
				end
			end
			for (int c = 0; c < NumChan; c++) begin
				if (start[c]) begin
					started = 1'b1;
					remain[c] = int'(length[c]);
					nextAddr[c] = baseAddr[c];
				end
			end
			if (sysCyc && !cycPrev) begin
				// word of the previous cycle has reached its channel by now
				checkSample(lastOwner);
				owner = nextOwner();
				if (owner < 0)
					flagError("bus cycle started with no words left");
				else if (sysAdr != nextAddr[owner] || int'(grantChan) != owner)
					flagError($sformatf("read of %h by channel %0d, expected %h by channel %0d",
						sysAdr, grantChan, nextAddr[owner], owner));
				acked = 1'b0;
			end
			if (sysCyc && cycPrev && !acked && owner >= 0 && sysAdr != nextAddr[owner])
				flagError($sformatf("sysAdr moved to %h during the read of %h", sysAdr,
					nextAddr[owner]));
			if (sysCyc && sysAck && !acked) begin
				acked = 1'b1;
				if (owner >= 0) begin
					expSample[owner] = nextAddr[owner][11:0] ^ 12'h5a5;
					nextAddr[owner] = nextAddr[owner] + 16'd1;
					remain[owner]--;
					lastOwner = owner;
				end
			end
			if (!sysCyc && cycPrev && !acked)
				flagError("sysCyc dropped before sysAck was seen");
			cycPrev = sysCyc;
			if (testDone)
				finishTest();
		end
	end

	task automatic finishTest();
		if (nextOwner() >= 0 || sysCyc || chanActive != '0)
			flagError("fetches still running when the test closed");
		if (int'(grantChan) != lastOwner || int'(grantChan) != expOwner)
			flagError($sformatf("grantChan %0d, expected last owner %0d", grantChan, expOwner));
		for (int c = 0; c < NumChan; c++) begin
			checkSample(c);
		end
		$display("test %0d: %s, %0d errors", testNum, (errs == 0) ? "ok" : "bad", errs);
		if (errs != 0)
			fails++;
		errs = 0;
	endtask

endmodule

//--- verilog/psgWaveFetch.sv
`timescale 1ns/1ps

module psgWaveFetch #(
	parameter int CeDiv = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [psgPkg::NumChan-1:0] start,
	input  psgPkg::busAddrT            baseAddr [psgPkg::NumChan],
	input  psgPkg::wordCntT            length [psgPkg::NumChan],
	input  psgPkg::sampleT             sysData,
	input  logic                       sysAck,
	output logic                       sysCyc,
	output psgPkg::busAddrT            sysAdr,
	output psgPkg::chanIdxT            grantChan,
	output psgPkg::sampleT             chanSample [psgPkg::NumChan],
	output logic [psgPkg::NumChan-1:0] chanActive
);

	import psgPkg::*;

	logic               ce;
	logic               busFree;
	logic               wordValid;
	sampleT             wordData;
	logic [NumChan-1:0] req;
	logic [NumChan-1:0] sel;
	busAddrT            chanAddr [NumChan];

	// ======================================================================
	// arbitration rate, arbiter and bus FSM
	// ======================================================================

	psgCeGen #(
		.CeDiv(CeDiv)
	) u_ceGen (
		.clk(clk),
		.rst(rst),
		.ce (ce)
	);

	// owner index goes straight out as grantChan
	psgBusArb u_busArb (
		.clk (clk),
		.rst (rst),
		.ce  (ce),
		.ack (busFree),
		.req (req),
		.sel (sel),
		.seln(grantChan)
	);

	psgFetchCtl u_fetchCtl (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.req      (req),
		.seln     (grantChan),
		.chanAddr (chanAddr),
		.sysAck   (sysAck),
		.sysData  (sysData),
		.sysCyc   (sysCyc),
		.sysAdr   (sysAdr),
		.busFree  (busFree),
		.wordValid(wordValid),
		.wordData (wordData)
	);

	// ======================================================================
	// wave-table channels
	// ======================================================================

	for (genvar i = 0; i < NumChan; i++) begin : g_chan
		psgWaveChannel u_chan (
			.clk      (clk),
			.rst      (rst),
			.start    (start[i]),
			.baseAddr (baseAddr[i]),
			.length   (length[i]),
			.sel      (sel[i]),
			.wordValid(wordValid),
			.wordData (wordData),
			.req      (req[i]),
			.addr     (chanAddr[i]),
			.sample   (chanSample[i]),
			.active   (chanActive[i])
		);
	end

endmodule

//--- verilog/psgWaveChannel.sv
`timescale 1ns/1ps

module psgWaveChannel (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  psgPkg::busAddrT baseAddr,
	input  psgPkg::wordCntT length,
	input  logic            sel,
	input  logic            wordValid,
	input  psgPkg::sampleT  wordData,
	output logic            req,
	output psgPkg::busAddrT addr,
	output psgPkg::sampleT  sample,
	output logic            active
);

	import psgPkg::*;

	wordCntT remain;
	logic    take;

	// word is ours only while we are the granted channel
	assign take = wordValid && sel && active;
	assign req  = active;

	// remaining-word counter and busy flag
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			remain <= '0;
		end else if (start && length != '0) begin
			active <= 1'b1;
			remain <= length;
		end else if (take) begin
			remain <= remain - wordCntT'(1);
			// last word, drop the request on this edge
			if (remain == wordCntT'(1)) begin
				active <= 1'b0;
			end
		end
	end

	// wave-table address walks up one word per fetch
	always_ff @(posedge clk) begin
		if (start && length != '0) begin
			addr <= baseAddr;
		end else if (take) begin
			addr <= addr + busAddrT'(1);
		end
	end

	// last delivered sample
	always_ff @(posedge clk) begin
		if (rst) begin
			sample <= '0;
		end else if (take) begin
			sample <= wordData;
		end
	end

endmodule

//--- verilog/psgFetchCtl.sv
`timescale 1ns/1ps

module psgFetchCtl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ce,
	input  logic [psgPkg::NumChan-1:0] req,
	input  psgPkg::chanIdxT            seln,
	input  psgPkg::busAddrT            chanAddr [psgPkg::NumChan],
	input  logic                       sysAck,
	input  psgPkg::sampleT             sysData,
	output logic                       sysCyc,
	output psgPkg::busAddrT            sysAdr,
	output logic                       busFree,
	output logic                       wordValid,
	output psgPkg::sampleT             wordData
);

	import psgPkg::*;

	fetchStateT state;
	logic       anyReq;

	// any request at all, the choice itself is made in the arbiter
	assign anyReq = |req;

	// the clock after a delivery the owner's req is still stale,
	// so the bus is not offered again until the channel has taken the word
	assign busFree = (state == Idle) && !wordValid;

	// ======================================================================
	// fetch FSM
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= Idle;
			sysCyc    <= 1'b0;
			wordValid <= 1'b0;
		end else begin
			wordValid <= 1'b0;
			case (state)
				Idle: begin
					// arbiter latches the new owner on this same edge
					if (ce && busFree && anyReq) begin
						state <= Grant;
					end
				end
				Grant: begin
					state  <= Bus;
					sysCyc <= 1'b1;
				end
				Bus: begin
					// a slow ack just keeps us here with the address held
					if (sysAck) begin
						state     <= Idle;
						sysCyc    <= 1'b0;
						wordValid <= 1'b1;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// address and returned word
	always_ff @(posedge clk) begin
		if (state == Grant) begin
			sysAdr <= chanAddr[seln];
		end
		if (state == Bus && sysAck) begin
			wordData <= sysData;
		end
	end

endmodule

//--- verilog/psgBusArb.sv
`timescale 1ns/1ps

module psgBusArb (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ce,
	input  logic                       ack,
	input  logic [psgPkg::NumChan-1:0] req,
	output logic [psgPkg::NumChan-1:0] sel,
	output psgPkg::chanIdxT            seln
);

	import psgPkg::*;

	chanIdxT              winner;
	logic [NumChan-1:0]   winnerHot;
	logic                 anyReq;

	assign anyReq = |req;

	// ======================================================================
	// fixed priority pick, channel 0 wins
	// ======================================================================

	// scan from the top down so the lowest requester is written last
	always_comb begin
		winner    = '0;
		winnerHot = '0;
		for (int i = NumChan - 1; i >= 0; i--) begin
			if (req[i]) begin
				winner    = chanIdxT'(i);
				winnerHot = '0;
				winnerHot[i] = 1'b1;
			end
		end
	end

	// ======================================================================
	// registered grant
	// ======================================================================

	// only re-decide on ce with the bus free
	// with no request the last owner is kept, so seln always names it
	always_ff @(posedge clk) begin
		if (rst) begin
			sel  <= '0;
			seln <= '0;
		end else if (ce && ack && anyReq) begin
			sel  <= winnerHot;
			seln <= winner;
		end
	end

endmodule

//--- verilog/psgCeGen.sv
`timescale 1ns/1ps

module psgCeGen #(
	parameter int CeDiv = 4
) (
	input  logic clk,
	input  logic rst,
	output logic ce
);

	// counter wide enough for CeDiv-1, at least one bit
	localparam int CntW = (CeDiv > 1) ? $clog2(CeDiv) : 1;

	logic [CntW-1:0] cnt;

	// down-counter, ce fires on the clock after it hits zero
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= CntW'(CeDiv - 1);
			ce  <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= CntW'(CeDiv - 1);
			ce  <= 1'b1;
		end else begin
			cnt <= cnt - CntW'(1);
			ce  <= 1'b0;
		end
	end

endmodule

//--- verilog/psgPkg.sv
package psgPkg;

	// ======================================================================
	// channel count and widths of the wave-table fetch path
	// ======================================================================

	// eight-way arbiter, so the channel count is fixed here
	localparam int NumChan = 8;

	// index of a wave-table channel
	typedef logic [2:0] chanIdxT;

	// system bus word address
	typedef logic [15:0] busAddrT;

	// one wave-table sample as it comes off the bus
	typedef logic [11:0] sampleT;

	// words a channel still has to fetch
	typedef logic [7:0] wordCntT;

	// fetch controller states
	typedef enum logic [1:0] {
		Idle,
		Grant,
		Bus
	} fetchStateT;

endpackage
